// ==== bus_watch.f ====
source/bus_watch_pkg.sv
source/bus_if.sv
source/cmd_fifo.sv
source/bus_master.sv
source/bus_slave.sv
source/bus_timeout.sv
source/bus_watch_top.sv
dv/bus_watch_assertions.sv
dv/bus_watch_checker.sv
dv/bus_watch_tb.sv

// ==== dv/bus_watch_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_watch_assertions (
	input wire logic                            clk_i,
	input wire logic                            rst_i,
	input wire logic                            cyc_i,
	input wire logic                            stb_i,
	input wire logic [bus_watch_pkg::ADR_W-1:0] adr_i,
	input wire logic                            ack_i,
	input wire logic                            err_i
);
	import bus_watch_pkg::*;

	// single-beat cycles only, so the strobe simply follows the cycle frame
	cyc_stb_equal: assert property (@(posedge clk_i) disable iff (rst_i)
		cyc_i == stb_i)
		else $error("cyc and stb differ on the internal bus");

	// the address is loaded with the rising cycle and must not move until it ends
	adr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
		(cyc_i && $past(cyc_i)) |-> (adr_i == $past(adr_i)))
		else $error("address changed in the middle of a bus cycle");

	// a cycle ends either by the slave or by the watchdog, never both
	ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i)
		!(ack_i && err_i))
		else $error("ack and err are high in the same clock");

	// the slow device is exempt from the watchdog
	no_err_at_slow: assert property (@(posedge clk_i) disable iff (rst_i)
		err_i |-> (adr_i != SLOW_ADR))
		else $error("watchdog raised err on the slow device address");

endmodule

`default_nettype wire

// ==== dv/bus_watch_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_watch_checker (
	input wire logic                            clk_i,
	input wire logic                            rst_i,
	input wire logic                            cmd_ready_i,
	input wire logic                            rsp_valid_i,
	input wire logic [bus_watch_pkg::DAT_W-1:0] rsp_dat_i,
	input wire logic                            rsp_err_i
);
	import bus_watch_pkg::*;

	// expected responses kept in the order the commands were accepted
	string            exp_name[$];
	logic [DAT_W-1:0] exp_dat[$];
	logic             exp_err[$];

	int               pass_cnt = 0;
	int               fail_cnt = 0;
	logic             saw_full = 1'b0;
	string            cur_name;
	logic [DAT_W-1:0] cur_dat;
	logic             cur_err;

	task automatic add_expect(input string name, input logic [DAT_W-1:0] dat,
		input logic err);
		exp_name.push_back(name);
		exp_dat.push_back(dat);
		exp_err.push_back(err);
	endtask

	function automatic int pending();
		return exp_dat.size();
	endfunction

	// ============================================================
	// response compare
	// ============================================================

	// each response pulse is matched against the oldest expected entry
	always @(negedge clk_i) begin
		if (!rst_i && !cmd_ready_i)
			saw_full = 1'b1;
		if (!rst_i && rsp_valid_i) begin
			if (exp_dat.size() == 0) begin
				$display("ERROR: a response arrived while no command was outstanding");
				fail_cnt++;
			end else begin
				cur_name = exp_name.pop_front();
				cur_dat  = exp_dat.pop_front();
				cur_err  = exp_err.pop_front();
				if (rsp_dat_i === cur_dat && rsp_err_i === cur_err) begin
					$display("PASS %s dat %h err %b", cur_name, rsp_dat_i, rsp_err_i);
					pass_cnt++;
				end else begin
					$display("FAIL %s: expected dat %h err %b, actual dat %h err %b",
						cur_name, cur_dat, cur_err, rsp_dat_i, rsp_err_i);
					fail_cnt++;
				end
			end
		end
	end

	// ============================================================
	// state checks requested by the testbench
	// ============================================================

	task automatic check_reset_state();
		if (cmd_ready_i !== 1'b1 || rsp_valid_i !== 1'b0) begin
			$display("ERROR: after reset ready is not high or a response is pending");
			fail_cnt++;
		end
	endtask

	// every command must be answered and the queue must have filled at least once
	task automatic check_end(input int n_sent);
		if (pass_cnt + fail_cnt != n_sent) begin
			$display("ERROR: %0d commands sent but %0d responses checked",
				n_sent, pass_cnt + fail_cnt);
			fail_cnt++;
		end
		if (!saw_full) begin
			$display("ERROR: cmd_ready_o never went low although the FIFO should fill");
			fail_cnt++;
		end
	endtask

endmodule

`default_nettype wire

// ==== dv/bus_watch_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_watch_tb;
	import bus_watch_pkg::*;

	localparam int FIFO_DEPTH     = 4;
	localparam int WAIT_STATES    = 2;
	localparam int SLOW_LATENCY   = 40;
	localparam int TIMEOUT_CYCLES = 16;
	localparam int DRIVE_DLY      = 2;

	// one command and the response it must produce
	typedef struct {
		string            name;
		logic             we;
		logic [ADR_W-1:0] adr;
		logic [DAT_W-1:0] dat;
		logic [DAT_W-1:0] exp_dat;
		logic             exp_err;
	} stim_t;

	logic             clk_i;
	logic             rst_i;
	logic             cmd_valid_i;
	logic             cmd_we_i;
	logic [ADR_W-1:0] cmd_adr_i;
	logic [DAT_W-1:0] cmd_dat_i;
	logic             cmd_ready_o;
	logic             rsp_valid_o;
	logic [DAT_W-1:0] rsp_dat_o;
	logic             rsp_err_o;

	stim_t stim_q[$];
	int    cycle_cnt   = 0;
	int    cycle_limit = 0;

	bus_watch_top #(
		.FIFO_DEPTH     (FIFO_DEPTH),
		.WAIT_STATES    (WAIT_STATES),
		.SLOW_LATENCY   (SLOW_LATENCY),
		.TIMEOUT_CYCLES (TIMEOUT_CYCLES)
	) UUT (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.cmd_valid_i (cmd_valid_i),
		.cmd_we_i    (cmd_we_i),
		.cmd_adr_i   (cmd_adr_i),
		.cmd_dat_i   (cmd_dat_i),
		.cmd_ready_o (cmd_ready_o),
		.rsp_valid_o (rsp_valid_o),
		.rsp_dat_o   (rsp_dat_o),
		.rsp_err_o   (rsp_err_o)
	);

	bus_watch_checker u_checker (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.cmd_ready_i (cmd_ready_o),
		.rsp_valid_i (rsp_valid_o),
		.rsp_dat_i   (rsp_dat_o),
		.rsp_err_i   (rsp_err_o)
	);

	bind bus_master bus_watch_assertions u_assertions (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.cyc_i (bus.cyc),
		.stb_i (bus.stb),
		.adr_i (bus.adr),
		.ack_i (bus.ack),
		.err_i (bus.err)
	);

	always #20 clk_i = ~clk_i;

	task automatic add_stim(input string name, input logic we, input logic [ADR_W-1:0] adr,
		input logic [DAT_W-1:0] dat, input logic [DAT_W-1:0] exp_dat, input logic exp_err);
		stim_t s;
		s.name    = name;
		s.we      = we;
		s.adr     = adr;
		s.dat     = dat;
		s.exp_dat = exp_dat;
		s.exp_err = exp_err;
		stim_q.push_back(s);
	endtask

	// ============================================================
	// stimulus table
	// ============================================================

	task automatic build_stim();
		// memory comes out of reset all zero
		for (int i = 0; i < 16; i++)
			add_stim($sformatf("rd_zero_%0d", i), 1'b0, 8'(i), '0, '0, 1'b0);
		// writes answer with zero data, reads return what was written
		add_stim("wr_mem_3", 1'b1, 8'h03, 16'hBEEF, '0, 1'b0);
		add_stim("rd_mem_3", 1'b0, 8'h03, '0, 16'hBEEF, 1'b0);
		add_stim("wr_mem_f", 1'b1, 8'h0F, 16'h1234, '0, 1'b0);
		add_stim("rd_mem_f", 1'b0, 8'h0F, '0, 16'h1234, 1'b0);
		// unmapped addresses are ended by the watchdog
		add_stim("rd_unmapped", 1'b0, 8'h42, '0, '0, 1'b1);
		add_stim("wr_unmapped", 1'b1, 8'h80, 16'hFFFF, '0, 1'b1);
		// slow device outlasts the watchdog limit but must not error
		add_stim("rd_slow", 1'b0, SLOW_ADR, '0, SLOW_ID, 1'b0);
		add_stim("wr_slow", 1'b1, SLOW_ADR, 16'h1111, '0, 1'b0);
		add_stim("rd_slow_again", 1'b0, SLOW_ADR, '0, SLOW_ID, 1'b0);
		// six in a row, more than the FIFO holds behind the running cycle
		add_stim("b2b_wr_5", 1'b1, 8'h05, 16'hA005, '0, 1'b0);
		add_stim("b2b_wr_6", 1'b1, 8'h06, 16'hA006, '0, 1'b0);
		add_stim("b2b_wr_7", 1'b1, 8'h07, 16'hA007, '0, 1'b0);
		add_stim("b2b_rd_5", 1'b0, 8'h05, '0, 16'hA005, 1'b0);
		add_stim("b2b_rd_6", 1'b0, 8'h06, '0, 16'hA006, 1'b0);
		add_stim("b2b_rd_7", 1'b0, 8'h07, '0, 16'hA007, 1'b0);
		// recovery right after an error-terminated cycle
		add_stim("rd_err_again", 1'b0, 8'h99, '0, '0, 1'b1);
		add_stim("rd_after_err", 1'b0, 8'h03, '0, 16'hBEEF, 1'b0);
	endtask

	// inputs change a little after the edge and are held until the next one
	task automatic send_cmd(input stim_t s);
		while (!cmd_ready_o) begin
			cmd_valid_i = 1'b0;
			@(posedge clk_i);
			#DRIVE_DLY;
		end
		cmd_valid_i = 1'b1;
		cmd_we_i    = s.we;
		cmd_adr_i   = s.adr;
		cmd_dat_i   = s.dat;
		u_checker.add_expect(s.name, s.exp_dat, s.exp_err);
		@(posedge clk_i);
		#DRIVE_DLY;
	endtask

	// ============================================================
	// main sequence
	// ============================================================

	initial begin
		clk_i       = 1'b0;
		rst_i       = 1'b1;
		cmd_valid_i = 1'b0;
		cmd_we_i    = 1'b0;
		cmd_adr_i   = '0;
		cmd_dat_i   = '0;
		build_stim();
		// worst case every command waits for the slow device plus some slack
		cycle_limit = stim_q.size() * (SLOW_LATENCY + 10) + 200;
		repeat (16) @(posedge clk_i);
		#DRIVE_DLY;
		rst_i = 1'b0;
		u_checker.check_reset_state();
		foreach (stim_q[i])
			send_cmd(stim_q[i]);
		cmd_valid_i = 1'b0;
		while (u_checker.pending() != 0)
			@(posedge clk_i);
		repeat (4) @(posedge clk_i);
		u_checker.check_end(stim_q.size());
		$display("tests %0d, passed %0d, failed %0d", stim_q.size(),
			u_checker.pass_cnt, u_checker.fail_cnt);
		if (u_checker.fail_cnt == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// watchdog for the testbench itself
	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
			$display("Testbench failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the bus watchdog testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module bus_watch_tb -f bus_watch.f \
	&& ./obj_dir/Vbus_watch_tb > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "^Testbench passed$" sim.log && echo "simulation ok" \
	|| { echo "simulation reported failure"; exit 1; }

// ==== source/bus_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface bus_if;
	import bus_watch_pkg::*;

	// cycle framing, cyc and stb rise and fall together in this design
	logic             cyc;
	logic             stb;
	logic             we;
	logic [ADR_W-1:0] adr;
	logic [DAT_W-1:0] dat_w;

	// slave response, ack is a one-cycle pulse
	logic [DAT_W-1:0] dat_r;
	logic             ack;

	// error pulse from the watchdog, it also ends the cycle
	logic             err;

	modport master (
		output cyc, stb, we, adr, dat_w,
		input  dat_r, ack, err
	);

	modport slave (
		input  cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);

	// the watchdog watches everything and only drives err
	modport monitor (
		input  cyc, stb, we, adr, dat_w, dat_r, ack,
		output err
	);

endinterface

`default_nettype wire

// ==== source/bus_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_master (
	input  wire logic                         clk_i,
	input  wire logic                         rst_i,
	input  wire logic                         empty_i,
	input  wire bus_watch_pkg::bus_cmd_t      head_i,
	output      logic                         pop_o,
	bus_if.master                             bus,
	output      logic                         rsp_valid_o,
	output      logic [bus_watch_pkg::DAT_W-1:0] rsp_dat_o,
	output      logic                         rsp_err_o
);
	import bus_watch_pkg::*;

	typedef enum logic {
		st_idle,
		st_active
	} state_t;

	state_t state;
	logic   cycle_done;

	// take the head whenever the bus is free and something is queued
	assign pop_o = (state == st_idle) && !empty_i;

	// either a slave ack or a watchdog error closes the running cycle
	assign cycle_done = (state == st_active) && (bus.ack || bus.err);

	// ============================================================
	// control state
	// ============================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state       <= st_idle;
			bus.cyc     <= 1'b0;
			bus.stb     <= 1'b0;
			rsp_valid_o <= 1'b0;
		end else begin
			// response strobe only lives for one clock
			rsp_valid_o <= 1'b0;
			if (pop_o) begin
				state   <= st_active;
				bus.cyc <= 1'b1;
				bus.stb <= 1'b1;
			end else if (cycle_done) begin
				state       <= st_idle;
				bus.cyc     <= 1'b0;
				bus.stb     <= 1'b0;
				rsp_valid_o <= 1'b1;
			end
		end
	end

	// ============================================================
	// payload registers
	// ============================================================

	always_ff @(posedge clk_i) begin
		// address and data are loaded once and held for the whole cycle
		if (pop_o) begin
			bus.we    <= head_i.we;
			bus.adr   <= head_i.adr;
			bus.dat_w <= head_i.dat;
		end
		// read data is only returned on a clean read, writes and errors give zero
		if (cycle_done) begin
			rsp_err_o <= bus.err;
			rsp_dat_o <= (!bus.err && !bus.we) ? bus.dat_r : '0;
		end
	end

endmodule

`default_nettype wire

// ==== source/bus_slave.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_slave #(
	parameter int WAIT_STATES  = 2,
	parameter int SLOW_LATENCY = 40
) (
	input  wire logic clk_i,
	input  wire logic rst_i,
	bus_if.slave      bus
);
	import bus_watch_pkg::*;

	// one spare bit so the saturating count never aliases onto a match
	localparam int MAX_LAT = (SLOW_LATENCY > WAIT_STATES) ? SLOW_LATENCY : WAIT_STATES;
	localparam int CNT_W   = $clog2(MAX_LAT + 1) + 1;

	logic [DAT_W-1:0] mem [16];
	logic [CNT_W-1:0] lat_cnt;
	logic             mem_hit;
	logic             slow_hit;
	logic             ack_next;

	// ============================================================
	// address decode
	// ============================================================

	assign mem_hit  = (bus.adr[ADR_W-1:4] == MEM_REGION);
	assign slow_hit = (bus.adr == SLOW_ADR);

	// anything else stays silent and is left to the watchdog
	assign ack_next = bus.cyc && bus.stb &&
		((mem_hit && (lat_cnt == CNT_W'(WAIT_STATES - 1))) ||
		 (slow_hit && (lat_cnt == CNT_W'(SLOW_LATENCY - 1))));

	// latency counter restarts whenever the bus goes idle
	// the master always leaves one idle clock between cycles
	always_ff @(posedge clk_i) begin
		if (rst_i || !bus.cyc)
			lat_cnt <= '0;
		else if (lat_cnt != '1)
			lat_cnt <= lat_cnt + 1'b1;
	end

	// ============================================================
	// response and memory
	// ============================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			bus.ack   <= 1'b0;
			bus.dat_r <= '0;
			// memory comes out of reset all zero
			for (int i = 0; i < 16; i++)
				mem[i] <= '0;
		end else begin
			// counter moves past the match value, so ack drops by itself
			bus.ack <= ack_next;
			if (ack_next) begin
				if (bus.we) begin
					bus.dat_r <= '0;
					// slow device swallows writes
					if (mem_hit)
						mem[bus.adr[3:0]] <= bus.dat_w;
				end else begin
					bus.dat_r <= mem_hit ? mem[bus.adr[3:0]] : SLOW_ID;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/bus_timeout.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_timeout #(
	parameter int TIMEOUT_CYCLES = 16
) (
	input  wire logic clk_i,
	input  wire logic rst_i,
	bus_if.monitor    bus
);
	import bus_watch_pkg::*;

	localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

	logic [CNT_W-1:0] to_cnt;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			bus.err <= 1'b0;
			to_cnt  <= CNT_W'(1);
		end else begin
			bus.err <= 1'b0;
			// an idle bus or an ack means nobody is waiting
			if (bus.ack || !bus.cyc)
				to_cnt <= CNT_W'(1);
			else if (to_cnt < CNT_W'(TIMEOUT_CYCLES))
				to_cnt <= to_cnt + 1'b1;
			// the slow device is known to take longer, so just start over
			else if (bus.stb && (bus.adr == SLOW_ADR))
				to_cnt <= CNT_W'(1);
			else begin
				// restart here too so err stays a single pulse while cyc drops
				bus.err <= 1'b1;
				to_cnt  <= CNT_W'(1);
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/bus_watch_pkg.sv ====
`default_nettype none

package bus_watch_pkg;

	// ============================================================
	// bus widths
	// ============================================================

	localparam int ADR_W = 8;
	localparam int DAT_W = 16;

	// one queued command, packed as write flag, address, write data
	// read commands carry don't-care data
	typedef struct packed {
		logic             we;
		logic [ADR_W-1:0] adr;
		logic [DAT_W-1:0] dat;
	} bus_cmd_t;

	// ============================================================
	// address map
	// ============================================================

	// upper nibble that selects the 16-word memory, low nibble picks the word
	localparam logic [3:0] MEM_REGION = 4'h0;

	// the slow device sits at one address and is exempt from the watchdog
	localparam logic [ADR_W-1:0] SLOW_ADR = 8'hF0;

	// fixed identification word the slow device returns on a read
	localparam logic [DAT_W-1:0] SLOW_ID = 16'h5A0D;

endpackage

`default_nettype wire

// ==== source/bus_watch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_watch_top #(
	parameter int FIFO_DEPTH     = 4,
	parameter int WAIT_STATES    = 2,
	parameter int SLOW_LATENCY   = 40,
	parameter int TIMEOUT_CYCLES = 16
) (
	input  wire logic                            clk_i,
	input  wire logic                            rst_i,
	input  wire logic                            cmd_valid_i,
	input  wire logic                            cmd_we_i,
	input  wire logic [bus_watch_pkg::ADR_W-1:0] cmd_adr_i,
	input  wire logic [bus_watch_pkg::DAT_W-1:0] cmd_dat_i,
	output      logic                            cmd_ready_o,
	output      logic                            rsp_valid_o,
	output      logic [bus_watch_pkg::DAT_W-1:0] rsp_dat_o,
	output      logic                            rsp_err_o
);
	import bus_watch_pkg::*;

	bus_cmd_t in_cmd;
	bus_cmd_t head_cmd;
	logic     fifo_full;
	logic     fifo_empty;
	logic     fifo_pop;

	bus_if u_bus ();

	// gather the loose command inputs into one queue entry
	assign in_cmd = '{we: cmd_we_i, adr: cmd_adr_i, dat: cmd_dat_i};

	// ready is simply the queue not being full
	assign cmd_ready_o = !fifo_full;

	cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.push_i     (cmd_valid_i),
		.push_cmd_i (in_cmd),
		.full_o     (fifo_full),
		.pop_i      (fifo_pop),
		.empty_o    (fifo_empty),
		.head_o     (head_cmd)
	);

	bus_master u_master (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.empty_i     (fifo_empty),
		.head_i      (head_cmd),
		.pop_o       (fifo_pop),
		.bus         (u_bus.master),
		.rsp_valid_o (rsp_valid_o),
		.rsp_dat_o   (rsp_dat_o),
		.rsp_err_o   (rsp_err_o)
	);

	bus_slave #(
		.WAIT_STATES  (WAIT_STATES),
		.SLOW_LATENCY (SLOW_LATENCY)
	) u_slave (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.bus   (u_bus.slave)
	);

	bus_timeout #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_timeout (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.bus   (u_bus.monitor)
	);

endmodule

`default_nettype wire

// ==== source/cmd_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module cmd_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire logic                  clk_i,
	input  wire logic                  rst_i,
	input  wire logic                  push_i,
	input  wire bus_watch_pkg::bus_cmd_t push_cmd_i,
	output      logic                  full_o,
	input  wire logic                  pop_i,
	output      logic                  empty_o,
	output      bus_watch_pkg::bus_cmd_t head_o
);
	import bus_watch_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	bus_cmd_t   mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// a push while full is dropped and the caller waits for ready instead
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	assign full_o  = (count == CNT_W'(FIFO_DEPTH));
	assign empty_o = (count == '0);

	// head is read straight from storage so a push shows up one clock later
	assign head_o = mem[rd_ptr];

	// storage is written only by accepted pushes
	always_ff @(posedge clk_i) begin
		if (do_push)
			mem[wr_ptr] <= push_cmd_i;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// pointers wrap explicitly so a depth that is not a power of two works
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// simultaneous push and pop leaves the occupancy unchanged
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire
